/* execution_unit.f */
hdl/cpu_types_pkg.sv
hdl/x86_decode_pkg.sv
hdl/decoded_instr_if.sv
hdl/register_file.sv
hdl/address_generator.sv
hdl/instruction_decoder.sv
hdl/decoded_instr_fifo.sv
hdl/mov_executor.sv
hdl/execution_unit.sv
verif/execution_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f execution_unit.f --top-module execution_unit_tb -o sim

# tee keeps the pipeline status so the log is always searched
./obj_dir/sim | tee sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
exit 0

/* verif/execution_unit_tb.sv */
`timescale 1ns/1ns

module execution_unit_tb
    import cpu_types_pkg::*;
();

    // instruction forms as the stream generator sees them
    localparam logic [1:0] F_RM_REG  = 2'd0;
    localparam logic [1:0] F_REG_RM  = 2'd1;
    localparam logic [1:0] F_REG_IMM = 2'd2;
    localparam logic [1:0] F_RM_IMM  = 2'd3;

    // 8 register loads, 24 addressing sweeps, random body, 8 closing stores
    localparam int NUM_RANDOM = 400;
    localparam int TOTAL      = 8 + 24 + NUM_RANDOM + 8;
    localparam int MAX_CYCLES = TOTAL * 60;

    typedef struct packed {
        logic [1:0] form;
        logic       w;
        reg_id_t    reg_f;
        reg_id_t    rm_f;
        logic [1:0] mod_f;
        word_t      disp;
        word_t      imm;
    } instr_t;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    byte_t      prefetch_data = 8'h00;
    logic       queue_empty = 1'b1;
    word_t      seg_ds = 16'h0000;
    word_t      seg_ss = 16'h0000;
    word_t      data_in = 16'h0000;
    logic       bus_command_done = 1'b0;
    logic       queue_pop;
    bus_cmd_e   bus_command;
    phys_addr_t bus_address;
    logic       bus_word;
    word_t      data_out;
    logic       instruction_done;

    // queue feeding starts only after the idle check
    logic        feed_enable = 1'b0;
    logic [31:0] lfsr_state = 32'h5ddd_d62a;

    // program as bytes and as decoded records for the model
    byte_t  code [$];
    instr_t program_list [TOTAL];
    int     program_len = 0;
    logic   program_built = 1'b0;
    int     byte_pos = 0;
    logic   bus_busy = 1'b0;
    int     wait_left = 0;

    // reference model state
    word_t  model_regs [8];
    int     retire_idx = 0;
    int     cycle_count = 0;

    always #4 clk = ~clk;

    execution_unit #(
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk              (clk),
        .reset            (reset),
        .prefetch_data    (prefetch_data),
        .queue_empty      (queue_empty),
        .queue_pop        (queue_pop),
        .seg_ds           (seg_ds),
        .seg_ss           (seg_ss),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_word         (bus_word),
        .data_out         (data_out),
        .data_in          (data_in),
        .bus_command_done (bus_command_done),
        .instruction_done (instruction_done)
    );

    // galois lfsr, one step per bit, bits collected msb first
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++)
        begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
        end
        return value;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input phys_addr_t actual, input phys_addr_t expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_cmd(input bus_cmd_e actual, input bus_cmd_e expected, input string what);
        if (actual !== expected)
        begin
            $display("ERR %0t: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one random instruction of the given form and addressing mode
    function automatic instr_t make_instr(logic [1:0] form, logic w, logic [1:0] mod_f,
                                          reg_id_t rm_f);
        instr_t ins;
        byte_t  d8;
        ins = '0;
        ins.form = form;
        ins.w = w;
        ins.rm_f = rm_f;
        // B0-BF have no ModR/M byte at all
        ins.mod_f = (form == F_REG_IMM) ? 2'b11 : mod_f;
        // C6/C7 carry /0 in the reg field
        ins.reg_f = (form == F_RM_IMM) ? 3'd0 : reg_id_t'(take_bits(3));
        if (ins.mod_f == 2'b01)
        begin
            d8 = byte_t'(take_bits(8));
            ins.disp = {{8{d8[7]}}, d8};
        end
        else if (ins.mod_f == 2'b10 || (ins.mod_f == 2'b00 && rm_f == 3'd6))
            ins.disp = word_t'(take_bits(16));
        ins.imm = w ? word_t'(take_bits(16)) : {8'h00, byte_t'(take_bits(8))};
        return ins;
    endfunction

    // append the record and its encoded bytes
    task automatic add_instr(input instr_t ins);
        program_list[program_len] = ins;
        program_len = program_len + 1;
        case (ins.form)
            F_RM_REG:  code.push_back({7'b1000100, ins.w});
            F_REG_RM:  code.push_back({7'b1000101, ins.w});
            F_REG_IMM: code.push_back({4'hB, ins.w, ins.reg_f});
            default:   code.push_back({7'b1100011, ins.w});
        endcase
        if (ins.form != F_REG_IMM)
        begin
            code.push_back({ins.mod_f, ins.reg_f, ins.rm_f});
            if (ins.mod_f == 2'b01)
                code.push_back(ins.disp[7:0]);
            else if (ins.mod_f == 2'b10 || (ins.mod_f == 2'b00 && ins.rm_f == 3'd6))
            begin
                code.push_back(ins.disp[7:0]);
                code.push_back(ins.disp[15:8]);
            end
        end
        if (ins.form == F_REG_IMM || ins.form == F_RM_IMM)
        begin
            code.push_back(ins.imm[7:0]);
            if (ins.w)
                code.push_back(ins.imm[15:8]);
        end
    endtask

    task automatic build_program();
        instr_t ins;
        // word loads so that every base and index register is non-zero
        for (int r = 0; r < 8; r++)
        begin
            ins = make_instr(F_REG_IMM, 1'b1, 2'b11, 3'd0);
            ins.reg_f = reg_id_t'(r);
            add_instr(ins);
        end
        // every rm with mod 00, 01 and 10
        for (int m = 0; m < 3; m++)
        begin
            for (int r = 0; r < 8; r++)
                add_instr(make_instr(F_RM_REG, 1'(take_bits(1)), 2'(m), reg_id_t'(r)));
        end
        for (int i = 0; i < NUM_RANDOM; i++)
            add_instr(make_instr(2'(take_bits(2)), 1'(take_bits(1)), 2'(take_bits(2)),
                                 reg_id_t'(take_bits(3))));
        // direct stores of all word registers expose the final register state
        for (int r = 0; r < 8; r++)
        begin
            ins = make_instr(F_RM_REG, 1'b1, 2'b00, 3'd6);
            ins.reg_f = reg_id_t'(r);
            add_instr(ins);
        end
        program_built = 1'b1;
    endtask

    // byte ids 4-7 are the high halves of registers 0-3
    function automatic word_t model_read(reg_id_t id, logic w);
        if (w)
            return model_regs[id];
        else if (id[2])
            return {8'h00, model_regs[id[1:0]][15:8]};
        else
            return {8'h00, model_regs[id[1:0]][7:0]};
    endfunction

    task automatic model_write(input reg_id_t id, input logic w, input word_t value);
        if (w)
            model_regs[id] = value;
        else if (id[2])
            model_regs[id[1:0]][15:8] = value[7:0];
        else
            model_regs[id[1:0]][7:0] = value[7:0];
    endtask

    // 16-bit offset by rm, SS for BP based modes, segment * 16 wrapping at 20 bits
    function automatic phys_addr_t expected_address(logic [1:0] mod_f, reg_id_t rm_f,
                                                    word_t disp);
        word_t offset;
        word_t segment;
        case (rm_f)
            3'd0:    offset = model_regs[3] + model_regs[6];
            3'd1:    offset = model_regs[3] + model_regs[7];
            3'd2:    offset = model_regs[5] + model_regs[6];
            3'd3:    offset = model_regs[5] + model_regs[7];
            3'd4:    offset = model_regs[6];
            3'd5:    offset = model_regs[7];
            3'd6:    offset = (mod_f == 2'b00) ? 16'h0000 : model_regs[5];
            default: offset = model_regs[3];
        endcase
        offset = offset + disp;
        segment = (rm_f == 3'd2 || rm_f == 3'd3 || (rm_f == 3'd6 && mod_f != 2'b00))
                  ? seg_ss : seg_ds;
        return {4'h0, segment} * 20'd16 + {4'h0, offset};
    endfunction

    task automatic retire_next();
        instr_t ins;
        logic   to_memory;
        word_t  expected_data;
        if (retire_idx >= program_len)
        begin
            $display("instruction_done pulsed with no instruction left to retire");
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            ins = program_list[retire_idx];
            retire_idx = retire_idx + 1;
            to_memory = (ins.form != F_REG_IMM) && (ins.mod_f != 2'b11);
            if (!to_memory)
            begin
                check_cmd(bus_command, BUS_IDLE, "bus command of a register move");
                case (ins.form)
                    F_RM_REG:  model_write(ins.rm_f, ins.w, model_read(ins.reg_f, ins.w));
                    F_REG_RM:  model_write(ins.reg_f, ins.w, model_read(ins.rm_f, ins.w));
                    F_REG_IMM: model_write(ins.reg_f, ins.w, ins.imm);
                    default:   model_write(ins.rm_f, ins.w, ins.imm);
                endcase
            end
            else
            begin
                check_addr(bus_address, expected_address(ins.mod_f, ins.rm_f, ins.disp),
                           "bus_address");
                check_bit(bus_word, ins.w, "bus_word");
                if (ins.form == F_REG_RM)
                begin
                    check_cmd(bus_command, BUS_READ, "bus command of a load");
                    model_write(ins.reg_f, ins.w, data_in);
                end
                else
                begin
                    check_cmd(bus_command, BUS_WRITE, "bus command of a store");
                    expected_data = (ins.form == F_RM_REG) ? model_read(ins.reg_f, ins.w)
                                                           : ins.imm;
                    // byte stores only carry the low 8 bits
                    check_word(bus_word ? data_out : (data_out & 16'h00ff), expected_data,
                               "data_out");
                end
            end
        end
    endtask

    // prefetch queue and bus models, all random draws happen here
    always @(posedge clk)
    begin
        if (reset)
        begin
            if (!program_built)
            begin
                build_program();
                seg_ds <= word_t'(take_bits(16));
                seg_ss <= word_t'(take_bits(16));
            end
            byte_pos = 0;
            bus_busy = 1'b0;
            wait_left = 0;
            queue_empty <= 1'b1;
            bus_command_done <= 1'b0;
        end
        else
        begin
            // the byte on offer was taken at this edge
            if (queue_pop)
                byte_pos = byte_pos + 1;
            if (feed_enable && byte_pos < code.size() && take_bits(2) != 0)
            begin
                queue_empty <= 1'b0;
                prefetch_data <= code[byte_pos];
            end
            else
            begin
                queue_empty <= 1'b1;
                prefetch_data <= byte_t'(take_bits(8));
            end
            // done lasts one cycle, 0 to 5 wait cycles before it
            bus_command_done <= 1'b0;
            if (bus_command != BUS_IDLE && !bus_command_done)
            begin
                if (!bus_busy)
                begin
                    bus_busy = 1'b1;
                    wait_left = int'(take_bits(3) % 6);
                end
                if (wait_left == 0)
                begin
                    bus_busy = 1'b0;
                    bus_command_done <= 1'b1;
                    data_in <= word_t'(take_bits(16));
                end
                else
                    wait_left = wait_left - 1;
            end
        end
    end

    // reference model runs in retirement order
    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                model_regs[i] = 16'h0000;
        end
        else if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycle_count, retire_idx, program_len);
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            cycle_count = cycle_count + 1;
            if (instruction_done)
                retire_next();
        end
    end

    initial
    begin
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // nothing may move while the queue stays empty
        repeat (4)
        begin
            @(posedge clk);
            check_bit(queue_pop, 1'b0, "queue_pop before the first byte");
            check_bit(instruction_done, 1'b0, "instruction_done before the first byte");
            check_cmd(bus_command, BUS_IDLE, "bus_command before the first byte");
        end
        feed_enable <= 1'b1;
        while (retire_idx < program_len)
            @(posedge clk);
        // stray pulses after the last instruction show up in the model
        repeat (20) @(posedge clk);
        if (retire_idx == program_len && byte_pos == code.size())
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d bytes were popped from the queue", byte_pos, code.size());
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

/* hdl/execution_unit.sv */
`timescale 1ns/1ns

module execution_unit
    import cpu_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic       clk,
    input  logic       reset,

    // prefetch queue
    input  byte_t      prefetch_data,
    input  logic       queue_empty,
    output logic       queue_pop,

    // segment values for address relocation
    input  word_t      seg_ds,
    input  word_t      seg_ss,

    // bus unit
    output bus_cmd_e   bus_command,
    output phys_addr_t bus_address,
    output logic       bus_word,
    output word_t      data_out,
    input  word_t      data_in,
    input  logic       bus_command_done,

    output logic       instruction_done
);

    // decoder to buffer, and buffer to executor
    decoded_instr_if decoded ();
    decoded_instr_if buffered ();

    instruction_decoder decoder_i
    (
        .clk           (clk),
        .reset         (reset),
        .prefetch_data (prefetch_data),
        .queue_empty   (queue_empty),
        .queue_pop     (queue_pop),
        .instr         (decoded.source)
    );

    decoded_instr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk   (clk),
        .reset (reset),
        .wr    (decoded.sink),
        .rd    (buffered.source)
    );

    mov_executor executor_i
    (
        .clk              (clk),
        .reset            (reset),
        .seg_ds           (seg_ds),
        .seg_ss           (seg_ss),
        .data_in          (data_in),
        .bus_command_done (bus_command_done),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_word         (bus_word),
        .data_out         (data_out),
        .instruction_done (instruction_done),
        .instr            (buffered.sink)
    );

endmodule

/* hdl/mov_executor.sv */
`timescale 1ns/1ns

module mov_executor
    import cpu_types_pkg::*;
    import x86_decode_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  word_t         seg_ds,
    input  word_t         seg_ss,
    input  word_t         data_in,
    input  logic          bus_command_done,
    output bus_cmd_e      bus_command,
    output phys_addr_t    bus_address,
    output logic          bus_word,
    output word_t         data_out,
    output logic          instruction_done,
    decoded_instr_if.sink instr
);

    typedef enum logic [1:0]
    {
        IDLE,
        BUS_WAIT,
        RETIRE_REG
    } state_e;

    state_e     state;

    // instruction in progress
    mov_kind_e  kind;
    logic       is_word;
    reg_id_t    reg_field;
    reg_id_t    rm_field;
    logic [1:0] mod;
    word_t      disp;
    // source value, taken from the register file or the immediate at acceptance
    word_t      operand;

    logic       accept;
    logic       to_memory;

    logic       reg_we;
    reg_id_t    write_id;
    word_t      write_data;
    reg_id_t    read_id_a;
    logic       read_word;
    word_t      read_data_a;
    word_t      read_data_b;
    reg_id_t    base_id;
    reg_id_t    index_id;

    // one instruction at a time
    assign instr.ready = state == IDLE;
    assign accept      = instr.valid && instr.ready;

    // every kind with an r/m operand goes to the bus unless mod selects a register
    assign to_memory = (instr.mod != MOD_REGISTER)
                    && (instr.kind != KIND_NOP) && (instr.kind != KIND_REG_FROM_IMM);

    // in IDLE port a fetches the source operand straight off the interface
    // afterwards both ports serve the address generator with word reads
    assign read_id_a = (state != IDLE) ? base_id :
                       (instr.kind == KIND_REG_FROM_RM) ? instr.rm_field : instr.reg_field;
    assign read_word = (state == IDLE) ? instr.is_word : 1'b1;

    // rm is the destination for 88/89 and C6/C7, reg for the rest
    assign write_id   = (kind == KIND_RM_FROM_REG || kind == KIND_RM_FROM_IMM) ? rm_field
                                                                               : reg_field;
    assign write_data = (state == BUS_WAIT) ? data_in : operand;
    assign reg_we     = (state == RETIRE_REG && kind != KIND_NOP)
                     || (state == BUS_WAIT && bus_command_done && kind == KIND_REG_FROM_RM);

    always_comb
    begin
        if (state != BUS_WAIT)
            bus_command = BUS_IDLE;
        else if (kind == KIND_REG_FROM_RM)
            bus_command = BUS_READ;
        else
            bus_command = BUS_WRITE;
    end

    // byte data sits in the low half of the operand
    assign bus_word = is_word;
    assign data_out = operand;

    assign instruction_done = (state == RETIRE_REG) || (state == BUS_WAIT && bus_command_done);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (accept)
                        state <= to_memory ? BUS_WAIT : RETIRE_REG;
                BUS_WAIT:
                    if (bus_command_done)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            kind      <= instr.kind;
            is_word   <= instr.is_word;
            reg_field <= instr.reg_field;
            rm_field  <= instr.rm_field;
            mod       <= instr.mod;
            disp      <= instr.disp;
            operand   <= (instr.kind == KIND_REG_FROM_IMM || instr.kind == KIND_RM_FROM_IMM)
                         ? instr.imm : read_data_a;
        end
    end

    register_file register_file_i
    (
        .clk         (clk),
        .reset       (reset),
        .we          (reg_we),
        .write_id    (write_id),
        .write_word  (is_word),
        .write_data  (write_data),
        .read_id_a   (read_id_a),
        .read_id_b   (index_id),
        .read_word   (read_word),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b)
    );

    address_generator address_generator_i
    (
        .mod              (mod),
        .rm               (rm_field),
        .disp             (disp),
        .base_value       (read_data_a),
        .index_value      (read_data_b),
        .seg_ds           (seg_ds),
        .seg_ss           (seg_ss),
        .base_id          (base_id),
        .index_id         (index_id),
        .physical_address (bus_address)
    );

endmodule

/* hdl/decoded_instr_fifo.sv */
`timescale 1ns/1ns

module decoded_instr_fifo
    import cpu_types_pkg::*;
    import x86_decode_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic            clk,
    input  logic            reset,
    decoded_instr_if.sink   wr,
    decoded_instr_if.source rd
);

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int KIND_W  = $bits(mov_kind_e);
    localparam int ENTRY_W = KIND_W + 1 + 2 * $bits(reg_id_t) + 2 + 2 * $bits(word_t);

    // one packed decoded instruction per slot
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               full;
    logic               push;
    logic               pop;
    logic [KIND_W-1:0]  head_kind;

    assign full = count == (PTR_W + 1)'(FIFO_DEPTH);

    // a full buffer still takes a new entry when the head leaves in the same cycle
    assign wr.ready = !full || rd.ready;
    assign rd.valid = count != '0;

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    assign {head_kind, rd.is_word, rd.reg_field, rd.rm_field, rd.mod, rd.disp, rd.imm} =
        mem[rd_ptr];
    assign rd.kind = mov_kind_e'(head_kind);

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= {wr.kind, wr.is_word, wr.reg_field, wr.rm_field, wr.mod,
                            wr.disp, wr.imm};
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            case ({push, pop})
                2'b10:   count <= count + (PTR_W + 1)'(1);
                2'b01:   count <= count - (PTR_W + 1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/instruction_decoder.sv */
`timescale 1ns/1ns

module instruction_decoder
    import cpu_types_pkg::*;
    import x86_decode_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  byte_t           prefetch_data,
    input  logic            queue_empty,
    output logic            queue_pop,
    decoded_instr_if.source instr
);

    typedef enum logic [2:0]
    {
        OPCODE,
        MODRM,
        DISP_LOW,
        DISP_HIGH,
        IMM_LOW,
        IMM_HIGH,
        OFFER
    } state_e;

    state_e     state;

    // instruction under assembly
    mov_kind_e  kind;
    logic       is_word;
    reg_id_t    reg_field;
    reg_id_t    rm_field;
    logic [1:0] mod;
    word_t      disp;
    word_t      imm;

    // class of the byte on prefetch_data when read as an opcode
    mov_kind_e  opc_kind;
    // the byte on prefetch_data, read as ModR/M, asks for a displacement
    logic       modrm_has_disp;
    // where to go once the displacement bytes are in
    state_e     after_disp;

    always_comb
    begin
        if (prefetch_data[7:1] == OPC_MOV_RM_REG[7:1])
            opc_kind = KIND_RM_FROM_REG;
        else if (prefetch_data[7:1] == OPC_MOV_REG_RM[7:1])
            opc_kind = KIND_REG_FROM_RM;
        else if (prefetch_data[7:1] == OPC_MOV_RM_IMM[7:1])
            opc_kind = KIND_RM_FROM_IMM;
        else if (prefetch_data[7:4] == OPC_MOV_REG_IMM[7:4])
            opc_kind = KIND_REG_FROM_IMM;
        else
            opc_kind = KIND_NOP;
    end

    // mod 01 and 10 always carry a displacement
    // mod 00 only for the direct address form rm 110
    assign modrm_has_disp = (prefetch_data[7:6] == 2'b01) || (prefetch_data[7:6] == 2'b10)
                         || (prefetch_data[7:6] == 2'b00 && prefetch_data[2:0] == 3'b110);

    // only C6/C7 have an immediate after the displacement
    assign after_disp = (kind == KIND_RM_FROM_IMM) ? IMM_LOW : OFFER;

    // pop in every fetch state as long as a byte is there
    assign queue_pop = (state != OFFER) && !queue_empty;

    assign instr.valid     = state == OFFER;
    assign instr.kind      = kind;
    assign instr.is_word   = is_word;
    assign instr.reg_field = reg_field;
    assign instr.rm_field  = rm_field;
    assign instr.mod       = mod;
    assign instr.disp      = disp;
    assign instr.imm       = imm;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= OPCODE;
        else if (state == OFFER)
        begin
            if (instr.ready)
                state <= OPCODE;
        end
        else if (!queue_empty)
        begin
            case (state)
                OPCODE:
                begin
                    kind      <= opc_kind;
                    // B0-BF keep the word bit in bit 3 and the register in bits 2:0
                    is_word   <= (opc_kind == KIND_REG_FROM_IMM) ? prefetch_data[3]
                                                                 : prefetch_data[0];
                    reg_field <= prefetch_data[2:0];
                    mod       <= MOD_REGISTER;
                    if (opc_kind == KIND_NOP)
                        state <= OFFER;
                    else if (opc_kind == KIND_REG_FROM_IMM)
                        state <= IMM_LOW;
                    else
                        state <= MODRM;
                end
                MODRM:
                begin
                    mod       <= prefetch_data[7:6];
                    reg_field <= prefetch_data[5:3];
                    rm_field  <= prefetch_data[2:0];
                    disp      <= '0;
                    state     <= modrm_has_disp ? DISP_LOW : after_disp;
                end
                DISP_LOW:
                begin
                    // disp8 is sign extended, a high byte may overwrite it
                    disp  <= {{8{prefetch_data[7]}}, prefetch_data};
                    state <= (mod == 2'b01) ? after_disp : DISP_HIGH;
                end
                DISP_HIGH:
                begin
                    disp[15:8] <= prefetch_data;
                    state      <= after_disp;
                end
                IMM_LOW:
                begin
                    imm   <= {8'h00, prefetch_data};
                    state <= is_word ? IMM_HIGH : OFFER;
                end
                IMM_HIGH:
                begin
                    imm[15:8] <= prefetch_data;
                    state     <= OFFER;
                end
                default:
                    state <= OPCODE;
            endcase
        end
    end

endmodule

/* hdl/address_generator.sv */
`timescale 1ns/1ns

module address_generator
    import cpu_types_pkg::*;
(
    input  logic [1:0] mod,
    input  reg_id_t    rm,
    input  word_t      disp,
    input  word_t      base_value,
    input  word_t      index_value,
    input  word_t      seg_ds,
    input  word_t      seg_ss,
    output reg_id_t    base_id,
    output reg_id_t    index_id,
    output phys_addr_t physical_address
);

    // word register numbers taking part in addressing
    localparam reg_id_t ID_BW = 3'd3;
    localparam reg_id_t ID_BP = 3'd5;
    localparam reg_id_t ID_IX = 3'd6;
    localparam reg_id_t ID_IY = 3'd7;

    logic  direct;
    word_t offset;
    word_t segment;

    // rm 0,1,7 on BW, rm 2,3,6 on BP, rm 4 and 5 on IX and IY alone
    always_comb
    begin
        case (rm)
            3'd0, 3'd1, 3'd7: base_id = ID_BW;
            3'd4:             base_id = ID_IX;
            3'd5:             base_id = ID_IY;
            default:          base_id = ID_BP;
        endcase
    end

    // only rm 0-3 add an index, even rm takes IX and odd rm IY
    assign index_id = rm[0] ? ID_IY : ID_IX;

    // mod 00 with rm 110 is a bare 16-bit address
    assign direct = (mod == 2'b00) && (rm == 3'd6);

    // offsets wrap at 16 bits
    always_comb
    begin
        if (direct)
            offset = disp;
        else if (!rm[2])
            offset = base_value + index_value + disp;
        else
            offset = base_value + disp;
    end

    // BP based modes default to the stack segment
    assign segment = (base_id == ID_BP && !direct) ? seg_ss : seg_ds;

    // segment * 16 + offset, wrapping at 1 MiB
    assign physical_address = {segment, 4'h0} + {4'h0, offset};

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ns

module register_file
    import cpu_types_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    we,
    input  reg_id_t write_id,
    input  logic    write_word,
    input  word_t   write_data,
    input  reg_id_t read_id_a,
    input  reg_id_t read_id_b,
    input  logic    read_word,
    output word_t   read_data_a,
    output word_t   read_data_b
);

    // AW, CW, DW, BW, SP, BP, IX, IY
    word_t regs [8];

    // byte ids 4-7 are the high halves of registers 0-3
    function automatic word_t read_reg(reg_id_t id);
        if (read_word)
            return regs[id];
        else if (id[2])
            return {8'h00, regs[id[1:0]][15:8]};
        else
            return {8'h00, regs[id[1:0]][7:0]};
    endfunction

    always_comb
    begin
        read_data_a = read_reg(read_id_a);
        read_data_b = read_reg(read_id_b);
    end

    // a byte write leaves the other half alone
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            if (write_word)
                regs[write_id] <= write_data;
            else if (write_id[2])
                regs[write_id[1:0]][15:8] <= write_data[7:0];
            else
                regs[write_id[1:0]][7:0] <= write_data[7:0];
        end
    end

endmodule

/* hdl/decoded_instr_if.sv */
`timescale 1ns/1ns

interface decoded_instr_if
    import cpu_types_pkg::*;
    import x86_decode_pkg::*;
();

    // handshake, transfer on a rising edge with both high
    logic       valid;
    logic       ready;

    // decoded fields, held stable while valid is high
    mov_kind_e  kind;
    logic       is_word;
    reg_id_t    reg_field;
    reg_id_t    rm_field;
    logic [1:0] mod;
    // disp is sign extended, imm is zero extended for byte operations
    word_t      disp;
    word_t      imm;

    modport source
    (
        output valid, kind, is_word, reg_field, rm_field, mod, disp, imm,
        input  ready
    );

    modport sink
    (
        input  valid, kind, is_word, reg_field, rm_field, mod, disp, imm,
        output ready
    );

endinterface

/* hdl/x86_decode_pkg.sv */
package x86_decode_pkg;

    import cpu_types_pkg::*;

    // class of a decoded instruction
    // anything outside the MOV family decodes to KIND_NOP and retires without effect
    typedef enum logic [2:0]
    {
        KIND_NOP          = 3'd0,
        KIND_RM_FROM_REG  = 3'd1,
        KIND_REG_FROM_RM  = 3'd2,
        KIND_REG_FROM_IMM = 3'd3,
        KIND_RM_FROM_IMM  = 3'd4
    } mov_kind_e;

    // opcode pairs with the word bit (bit 0) clear
    // 88/89 register to r/m
    localparam byte_t OPC_MOV_RM_REG = 8'h88;
    // 8A/8B r/m to register
    localparam byte_t OPC_MOV_REG_RM = 8'h8A;
    // C6/C7 immediate to r/m
    localparam byte_t OPC_MOV_RM_IMM = 8'hC6;

    // B0-BF group base, bit 3 is the word bit and bits 2:0 the register
    localparam byte_t OPC_MOV_REG_IMM = 8'hB0;

    // mod 11 means rm names a register instead of memory
    localparam logic [1:0] MOD_REGISTER = 2'b11;

endpackage

/* hdl/cpu_types_pkg.sv */
package cpu_types_pkg;

    // one instruction or data byte
    typedef logic [7:0] byte_t;

    // register, immediate, displacement or bus data
    typedef logic [15:0] word_t;

    // physical memory address after segment relocation
    typedef logic [19:0] phys_addr_t;

    // register number from a ModR/M field or opcode low bits
    // word access uses 0-7 as AW, CW, DW, BW, SP, BP, IX, IY
    // byte access uses 0-3 as AL, CL, DL, BL and 4-7 as AH, CH, DH, BH
    typedef logic [2:0] reg_id_t;

    // command towards the bus unit
    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_cmd_e;

endpackage
